// ==== ac97_defines.svh ====
`ifndef AC97_DEFINES_SVH
`define AC97_DEFINES_SVH

// ----------------------------------------
// register map, byte offsets on addr[19:0]
// ----------------------------------------
`define AC97_REG_PLAY        20'h00000  // play sample, write only
`define AC97_REG_REC         20'h00004  // record sample, read only
`define AC97_REG_STAT        20'h00008  // status byte, read only
`define AC97_REG_FIFO_RST    20'h0000C  // fifo reset bits, write only
`define AC97_REG_CODEC_ADDR  20'h00010  // codec command, write only
`define AC97_REG_CODEC_RD    20'h00014  // codec read data
`define AC97_REG_CODEC_WR    20'h00018  // codec write data

// ----------------------------------------
// stream timing and sizes
// ----------------------------------------
`define AC97_FIFO_DEPTH      16         // pairs per fifo
`define AC97_TICK_RUN        2604       // cycles per short 48k period
`define AC97_TICK_FRAC       6          // periods per long run, also per 8k tick
`define AC97_RESET_DELAY     32         // cycles until codec ready

// interrupt thresholds
`define AC97_PLAY_IRQ_MAX    7          // play half empty
`define AC97_REC_IRQ_MIN     8          // record half full

`endif

// ==== ac97_bus_pkg.sv ====
package ac97_bus_pkg;

  // ----------------------------------------
  // register bus request and response
  // ----------------------------------------
  typedef struct packed {
    logic [31:0] addr;             // byte address, low 20 bits decoded
    logic [31:0] wdata;            // raw write word
    logic        we;               // write enable strobe
    logic        re;               // read enable strobe
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;            // valid together with ack
    logic        ack;              // one cycle after enable
  } bus_rsp_t;

  // ----------------------------------------
  // views of one write word
  // ----------------------------------------
  typedef struct packed {
    logic [15:0] rsvd;
    logic [15:0] sample;           // play sample or codec data
  } wdata_smp_t;

  typedef struct packed {
    logic [29:0] rsvd;
    logic        rec;              // clear record fifo
    logic        play;             // clear play fifo
  } wdata_rst_t;

  typedef struct packed {
    logic [23:0] rsvd;
    logic        rd;               // 1 read, 0 write
    logic [5:0]  addr;             // codec word address
    logic        rsvd0;
  } wdata_cmd_t;

  typedef union packed {
    wdata_smp_t smp;
    wdata_rst_t fifo_rst;
    wdata_cmd_t cmd;
  } bus_wdata_u;

endpackage

// ==== ac97_audio_pkg.sv ====
package ac97_audio_pkg;

  // ----------------------------------------
  // one stereo sample
  // ----------------------------------------
  typedef struct packed {
    logic [15:0] right;            // upper half
    logic [15:0] left;             // lower half
  } sample_pair_t;

  // ----------------------------------------
  // fifo fill state
  // ----------------------------------------
  typedef struct packed {
    logic [4:0] count;             // pairs held, 0..16
    logic       empty;
    logic       full;
  } fifo_stat_t;

endpackage

// ==== ac97_sample_tick.sv ====
`include "ac97_defines.svh"

module ac97_sample_tick (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  output logic tick_48k_o,
  output logic tick_8k_o
);

  localparam int FRAC_LAST = `AC97_TICK_FRAC - 1;

  logic [11:0] cyc_q;              // cycles in current period
  logic [2:0]  frac_q;             // period index within six
  logic        long_run;           // this period is one cycle longer
  logic [11:0] last_cyc;           // terminal count of this period

  assign long_run = (frac_q == 3'(FRAC_LAST));
  assign last_cyc = long_run ? 12'(`AC97_TICK_RUN) : 12'(`AC97_TICK_RUN - 1);

  // ----------------------------------------
  // fractional divider
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      cyc_q      <= '0;
      frac_q     <= '0;
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
    end else begin
      tick_48k_o <= 1'b0;                        // strobes last one cycle
      tick_8k_o  <= 1'b0;
      if (cyc_q == last_cyc) begin
        cyc_q      <= '0;                        // period done
        tick_48k_o <= 1'b1;
        tick_8k_o  <= long_run;                  // every sixth tick
        frac_q     <= long_run ? 3'd0 : frac_q + 3'd1;
      end else begin
        cyc_q <= cyc_q + 12'd1;
      end
    end
  end

endmodule

// ==== ac97_reg_decode.sv ====
`include "ac97_defines.svh"

module ac97_reg_decode
  import ac97_bus_pkg::*, ac97_audio_pkg::*;
(
  input  logic         clk_adc_125mhz,
  input  logic         adc_rstn_i,
  input  logic         codec_ready_i,
  input  bus_req_t     bus_req_i,
  output bus_rsp_t     bus_rsp_o,
  output logic         play_push_o,
  output sample_pair_t play_pair_o,
  output logic         play_rst_o,
  input  sample_pair_t rec_head_i,
  input  fifo_stat_t   rec_stat_i,
  input  fifo_stat_t   play_stat_i,
  output logic         rec_pop_o,
  output logic         rec_rst_o,
  input  logic         underrun_i,
  input  logic         overrun_i,
  output logic         codec_acc_o,
  output logic         codec_rd_o,
  output logic [5:0]   codec_addr_o,
  output logic [15:0]  codec_wdata_o,
  input  logic [15:0]  codec_rdata_i,
  input  logic         codec_done_i
);

  bus_wdata_u   wdat;              // decoded write word
  logic [19:0]  offs;              // register offset
  logic         wr_en;             // accepted write
  logic         rd_en;
  logic         play_right_q;      // next play write is right
  logic         rec_right_q;       // next rec read is right
  logic [7:0]   stat_byte;
  sample_pair_t play_pair_q;
  logic [15:0]  codec_wdata_q;
  bus_rsp_t     rsp_q;

  assign wdat  = bus_req_i.wdata;
  assign offs  = bus_req_i.addr[19:0];
  assign wr_en = bus_req_i.we && codec_ready_i;  // writes dropped until ready
  assign rd_en = bus_req_i.re;

  assign stat_byte = {overrun_i, underrun_i, codec_ready_i, codec_done_i,
                      rec_stat_i.empty, rec_stat_i.full,
                      (play_stat_i.count <= 5'(`AC97_FIFO_DEPTH / 2)),
                      play_stat_i.full};

  // codec command goes straight to the store
  assign codec_acc_o   = wr_en && (offs == `AC97_REG_CODEC_ADDR);
  assign codec_rd_o    = wdat.cmd.rd;
  assign codec_addr_o  = wdat.cmd.addr;
  assign codec_wdata_o = codec_wdata_q;

  // right half read releases the head pair
  assign rec_pop_o = rd_en && (offs == `AC97_REG_REC) && rec_right_q && !rec_stat_i.empty;

  assign play_pair_o = play_pair_q;
  assign bus_rsp_o   = rsp_q;

  // ----------------------------------------
  // write side control
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_right_q <= 1'b0;
      play_push_o  <= 1'b0;
      play_rst_o   <= 1'b0;
      rec_rst_o    <= 1'b0;
    end else begin
      play_push_o <= 1'b0;                       // pulses by default
      play_rst_o  <= 1'b0;
      rec_rst_o   <= 1'b0;
      if (wr_en && (offs == `AC97_REG_PLAY)) begin
        play_right_q <= !play_right_q;
        play_push_o  <= play_right_q;            // pair complete after right
      end
      if (wr_en && (offs == `AC97_REG_FIFO_RST)) begin
        play_rst_o <= wdat.fifo_rst.play;
        rec_rst_o  <= wdat.fifo_rst.rec;
        if (wdat.fifo_rst.play) begin
          play_right_q <= 1'b0;                  // restart pairing at left
        end
      end
    end
  end

  // sample and codec data holding
  always_ff @(posedge clk_adc_125mhz) begin
    if (wr_en && (offs == `AC97_REG_PLAY)) begin
      if (play_right_q) begin
        play_pair_q.right <= wdat.smp.sample;
      end else begin
        play_pair_q.left <= wdat.smp.sample;
      end
    end
    if (wr_en && (offs == `AC97_REG_CODEC_WR)) begin
      codec_wdata_q <= wdat.smp.sample;
    end
  end

  // ----------------------------------------
  // read mux and acknowledge
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      rsp_q       <= '0;
      rec_right_q <= 1'b0;
    end else begin
      rsp_q.ack   <= bus_req_i.we || bus_req_i.re;  // every access acked
      rsp_q.rdata <= '0;
      if (wr_en && (offs == `AC97_REG_FIFO_RST) && wdat.fifo_rst.rec) begin
        rec_right_q <= 1'b0;
      end
      if (rd_en) begin
        case (offs)
          `AC97_REG_REC: begin
            if (!rec_stat_i.empty) begin         // empty reads zero, no toggle
              rsp_q.rdata <= {16'h0, rec_right_q ? rec_head_i.right : rec_head_i.left};
              rec_right_q <= !rec_right_q;
            end
          end
          `AC97_REG_STAT:     rsp_q.rdata <= {24'h0, stat_byte};
          `AC97_REG_CODEC_RD: rsp_q.rdata <= {16'h0, codec_rdata_i};
          default:            rsp_q.rdata <= '0;  // write only or unmapped
        endcase
      end
    end
  end

endmodule

// ==== ac97_sample_fifo.sv ====
`include "ac97_defines.svh"

module ac97_sample_fifo
  import ac97_audio_pkg::*;
#(
  parameter bit OUT_REG = 1'b0                   // 1 holds popped pair at output
) (
  input  logic         clk_adc_125mhz,
  input  logic         adc_rstn_i,
  input  logic         clr_i,
  input  logic         push_i,
  input  sample_pair_t push_pair_i,
  input  logic         pop_i,
  output sample_pair_t head_o,
  output fifo_stat_t   stat_o
);

  localparam int AW = $clog2(`AC97_FIFO_DEPTH);

  sample_pair_t  mem [`AC97_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          do_push;          // push that is taken
  logic          do_pop;           // pop that is taken

  assign stat_o.count = count_q;
  assign stat_o.empty = (count_q == '0);
  assign stat_o.full  = (count_q == (AW + 1)'(`AC97_FIFO_DEPTH));

  assign do_push = push_i && !stat_o.full;      // full drops the pair
  assign do_pop  = pop_i && !stat_o.empty;

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) mem[wr_ptr_q] <= push_pair_i;
  end

  generate
    if (OUT_REG) begin : g_out_reg
      sample_pair_t out_q;                       // line output register
      always_ff @(posedge clk_adc_125mhz) begin
        if (do_pop) out_q <= mem[rd_ptr_q];
      end
      assign head_o = out_q;
    end else begin : g_fwft
      assign head_o = mem[rd_ptr_q];             // head always visible
    end
  endgenerate

endmodule

// ==== ac97_codec_regs.sv ====
module ac97_codec_regs (
  input  logic        clk_adc_125mhz,
  input  logic        adc_rstn_i,
  input  logic        acc_i,
  input  logic        rd_i,
  input  logic [5:0]  addr_i,
  input  logic [15:0] wdata_i,
  output logic [15:0] rdata_o,
  output logic        done_o
);

  logic [15:0] mem [64];           // codec register image
  logic        pend_q;             // access in flight

  // ----------------------------------------
  // store and read-data register
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (acc_i && !rd_i) begin
      mem[addr_i] <= wdata_i;                    // write command
    end
    if (acc_i && rd_i) begin
      rdata_o <= mem[addr_i];                    // read command
    end
  end

  // access finished two cycles after command
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      done_o <= 1'b1;
      pend_q <= 1'b0;
    end else if (acc_i) begin
      done_o <= 1'b0;
      pend_q <= 1'b1;
    end else if (pend_q) begin
      done_o <= 1'b1;
      pend_q <= 1'b0;
    end
  end

endmodule

// ==== ac97_stream_status.sv ====
`include "ac97_defines.svh"

module ac97_stream_status
  import ac97_audio_pkg::*;
(
  input  logic       clk_adc_125mhz,
  input  logic       adc_rstn_i,
  input  logic       tick_48k_i,
  input  fifo_stat_t play_stat_i,
  input  fifo_stat_t rec_stat_i,
  input  logic       play_rst_i,
  input  logic       rec_rst_i,
  output logic       codec_ready_o,
  output logic       underrun_o,
  output logic       overrun_o,
  output logic       irq_play_o,
  output logic       irq_rec_o
);

  localparam int DW = $clog2(`AC97_RESET_DELAY);

  logic [DW-1:0] delay_q;          // cycles left before ready

  // ----------------------------------------
  // reset delay and codec ready
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      delay_q       <= DW'(`AC97_RESET_DELAY - 1);
      codec_ready_o <= 1'b0;
    end else if (delay_q != '0) begin
      delay_q <= delay_q - 1'b1;
    end else begin
      codec_ready_o <= 1'b1;                     // stays until next reset
    end
  end

  // sticky stream errors, cleared by fifo reset
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      underrun_o <= 1'b0;
      overrun_o  <= 1'b0;
    end else begin
      if (play_rst_i) begin
        underrun_o <= 1'b0;
      end else if (codec_ready_o && tick_48k_i && play_stat_i.empty) begin
        underrun_o <= 1'b1;                      // nothing to play
      end
      if (rec_rst_i) begin
        overrun_o <= 1'b0;
      end else if (codec_ready_o && tick_48k_i && rec_stat_i.full) begin
        overrun_o <= 1'b1;                       // input pair lost
      end
    end
  end

  // ----------------------------------------
  // level interrupts
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      irq_play_o <= 1'b0;
      irq_rec_o  <= 1'b0;
    end else begin
      irq_play_o <= (play_stat_i.count <= 5'(`AC97_PLAY_IRQ_MAX));  // half empty
      irq_rec_o  <= (rec_stat_i.count >= 5'(`AC97_REC_IRQ_MIN));    // half full
    end
  end

endmodule

// ==== ac97_ctrl_top.sv ====
module ac97_ctrl_top
  import ac97_bus_pkg::*, ac97_audio_pkg::*;
(
  input  logic         clk_adc_125mhz,
  input  logic         adc_rstn_i,
  input  bus_req_t     bus_req_i,
  output bus_rsp_t     bus_rsp_o,
  input  sample_pair_t line_in_i,
  output sample_pair_t line_out_o,
  output logic         tick_48k_o,
  output logic         tick_8k_o,
  output logic         irq_play_o,
  output logic         irq_rec_o
);

  logic         tick_48k;
  logic         codec_ready;
  logic         underrun;
  logic         overrun;
  logic         play_push;
  logic         play_rst;
  logic         rec_pop;
  logic         rec_rst;
  sample_pair_t play_pair;
  sample_pair_t rec_head;
  fifo_stat_t   play_stat;
  fifo_stat_t   rec_stat;
  logic         codec_acc;
  logic         codec_rd;
  logic [5:0]   codec_addr;
  logic [15:0]  codec_wdata;
  logic [15:0]  codec_rdata;
  logic         codec_done;

  assign tick_48k_o = tick_48k;

  // ----------------------------------------
  // sample rate strobes
  // ----------------------------------------
  ac97_sample_tick i_tick (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .tick_48k_o     (tick_48k),
    .tick_8k_o      (tick_8k_o)
  );

  ac97_reg_decode i_decode (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .codec_ready_i  (codec_ready),
    .bus_req_i      (bus_req_i),
    .bus_rsp_o      (bus_rsp_o),
    .play_push_o    (play_push),
    .play_pair_o    (play_pair),
    .play_rst_o     (play_rst),
    .rec_head_i     (rec_head),
    .rec_stat_i     (rec_stat),
    .play_stat_i    (play_stat),
    .rec_pop_o      (rec_pop),
    .rec_rst_o      (rec_rst),
    .underrun_i     (underrun),
    .overrun_i      (overrun),
    .codec_acc_o    (codec_acc),
    .codec_rd_o     (codec_rd),
    .codec_addr_o   (codec_addr),
    .codec_wdata_o  (codec_wdata),
    .codec_rdata_i  (codec_rdata),
    .codec_done_i   (codec_done)
  );

  // ----------------------------------------
  // sample fifos
  // ----------------------------------------
  ac97_sample_fifo #(.OUT_REG(1'b1)) i_play_fifo (  // head is line out
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .clr_i          (play_rst),
    .push_i         (play_push),
    .push_pair_i    (play_pair),
    .pop_i          (tick_48k),
    .head_o         (line_out_o),
    .stat_o         (play_stat)
  );

  ac97_sample_fifo #(.OUT_REG(1'b0)) i_rec_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .clr_i          (rec_rst),
    .push_i         (tick_48k),                  // line in sampled per tick
    .push_pair_i    (line_in_i),
    .pop_i          (rec_pop),
    .head_o         (rec_head),
    .stat_o         (rec_stat)
  );

  ac97_codec_regs i_codec (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .acc_i          (codec_acc),
    .rd_i           (codec_rd),
    .addr_i         (codec_addr),
    .wdata_i        (codec_wdata),
    .rdata_o        (codec_rdata),
    .done_o         (codec_done)
  );

  ac97_stream_status i_status (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .tick_48k_i     (tick_48k),
    .play_stat_i    (play_stat),
    .rec_stat_i     (rec_stat),
    .play_rst_i     (play_rst),
    .rec_rst_i      (rec_rst),
    .codec_ready_o  (codec_ready),
    .underrun_o     (underrun),
    .overrun_o      (overrun),
    .irq_play_o     (irq_play_o),
    .irq_rec_o      (irq_rec_o)
  );

endmodule

// ==== ac97_ctrl_asserts.sv ====
module ac97_ctrl_asserts
  import ac97_bus_pkg::*, ac97_audio_pkg::*;
(
  input logic         clk_adc_125mhz,
  input logic         adc_rstn_i,
  input bus_req_t     bus_req_i,
  input bus_rsp_t     rsp_i,
  input sample_pair_t line_out_i,
  input logic         tick_48k_i,
  input logic         tick_8k_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;       // read by the testbench at the end

  // ----------------------------------------
  // bus acknowledge timing
  // ----------------------------------------
  a_ack_after_en: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    (bus_req_i.we || bus_req_i.re) |=> rsp_i.ack)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("acknowledge missing one cycle after a bus enable");
    end

  a_ack_has_en: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    rsp_i.ack |-> $past(bus_req_i.we || bus_req_i.re))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("acknowledge without a bus enable the cycle before");
    end

  // ----------------------------------------
  // stream strobes and line output
  // ----------------------------------------
  a_8k_in_48k: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    tick_8k_i |-> tick_48k_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("8 kHz tick outside a 48 kHz tick");
    end

  a_line_after_tick: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    !$stable(line_out_i) |-> $past(tick_48k_i))  // output moves only on a pop
    else begin
      fail_cnt = fail_cnt + 1;
      $error("line output changed without a preceding tick");
    end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int HALF_NS    = 4,                  // 8 ns period
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rstn_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;                               // held low from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;                              // released on an edge
  end

endmodule

// ==== tb_ac97_ctrl.sv ====
`include "ac97_defines.svh"

module tb_ac97_ctrl
  import ac97_bus_pkg::*, ac97_audio_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [2:0] OP_IDLE  = 3'd0;       // data = cycles
  localparam logic [2:0] OP_WR    = 3'd1;
  localparam logic [2:0] OP_RD    = 3'd2;       // compare with exp column
  localparam logic [2:0] OP_REC   = 3'd3;       // data = reads, model gives exp
  localparam logic [2:0] OP_STAT  = 3'd4;       // status and irqs from model
  localparam logic [2:0] OP_TICKS = 3'd5;       // data = 48k ticks
  localparam logic [2:0] OP_FILL  = 3'd6;       // data = play pairs written
  localparam int         N_ROWS   = 43;

  typedef struct packed {
    logic [2:0]  op;
    logic [19:0] offs;
    logic [31:0] data;
    logic [31:0] exp;
  } row_t;

  row_t tbl [N_ROWS] = '{
    '{OP_IDLE,  20'h0,                32'd40,        32'h0},  // wait for codec ready
    '{OP_RD,    `AC97_REG_STAT,       32'h0,         32'h3A},
    '{OP_WR,    `AC97_REG_CODEC_WR,   32'hABCD_1234, 32'h0},  // upper half ignored
    '{OP_WR,    `AC97_REG_CODEC_ADDR, 32'h0000_000A, 32'h0},  // write word 5
    '{OP_WR,    `AC97_REG_CODEC_WR,   32'h0000_BEEF, 32'h0},
    '{OP_WR,    `AC97_REG_CODEC_ADDR, 32'h0000_0054, 32'h0},  // write word 42
    '{OP_WR,    `AC97_REG_CODEC_ADDR, 32'h0000_008A, 32'h0},  // read word 5
    '{OP_IDLE,  20'h0,                32'd2,         32'h0},
    '{OP_RD,    `AC97_REG_CODEC_RD,   32'h0,         32'h1234},
    '{OP_WR,    `AC97_REG_CODEC_ADDR, 32'h0000_00D4, 32'h0},  // read word 42
    '{OP_IDLE,  20'h0,                32'd2,         32'h0},
    '{OP_RD,    `AC97_REG_CODEC_RD,   32'h0,         32'hBEEF},
    '{OP_RD,    `AC97_REG_STAT,       32'h0,         32'h3A},  // access finished again
    '{OP_RD,    20'h0001C,            32'h0,         32'h0},   // unmapped
    '{OP_RD,    `AC97_REG_PLAY,       32'h0,         32'h0},   // write only
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_1111, 32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_2222, 32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_3333, 32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_4444, 32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_5555, 32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_6666, 32'h0},
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_TICKS, 20'h0,                32'd1,         32'h0},
    '{OP_REC,   20'h0,                32'd2,         32'h0},
    '{OP_TICKS, 20'h0,                32'd2,         32'h0},   // play fifo drained
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_TICKS, 20'h0,                32'd1,         32'h0},   // underrun tick
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_REC,   20'h0,                32'd7,         32'h0},   // last read hits empty
    '{OP_TICKS, 20'h0,                32'd18,        32'h0},   // record overrun
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_REC,   20'h0,                32'd3,         32'h0},   // stops on a left half
    '{OP_FILL,  20'h0,                32'd17,        32'h0},   // one pair past full
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_7777, 32'h0},   // left left dangling
    '{OP_WR,    `AC97_REG_FIFO_RST,   32'h0000_0003, 32'h0},
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_AAAA, 32'h0},
    '{OP_WR,    `AC97_REG_PLAY,       32'h0000_BBBB, 32'h0},
    '{OP_STAT,  20'h0,                32'h0,         32'h0},
    '{OP_TICKS, 20'h0,                32'd1,         32'h0},
    '{OP_REC,   20'h0,                32'd2,         32'h0},
    '{OP_STAT,  20'h0,                32'h0,         32'h0}
  };

  logic         clk_adc_125mhz;
  logic         adc_rstn;
  bus_req_t     bus_req;
  bus_rsp_t     bus_rsp;
  sample_pair_t line_in;
  sample_pair_t line_out;
  logic         tick_48k;
  logic         tick_8k;
  logic         irq_play;
  logic         irq_rec;

  // reference model state
  sample_pair_t play_q [$];
  sample_pair_t rec_q [$];
  logic         play_right_m = 1'b0;
  logic [15:0]  play_left_m  = '0;
  logic         rec_right_m  = 1'b0;
  logic         underrun_m   = 1'b0;
  logic         overrun_m    = 1'b0;
  sample_pair_t line_exp;
  logic         line_due     = 1'b0;  // line_out compare pending
  logic [31:0]  rng;
  int           gap_cnt      = 0;     // cycles since last tick
  int           n_48k        = 0;     // 48k ticks so far
  logic         long_exp;             // this period is the long one
  int           since_8k     = 0;
  int           n_8k         = 0;

  tb_clock_gen i_clk (
    .clk_o  (clk_adc_125mhz),
    .rstn_o (adc_rstn)
  );

  ac97_ctrl_top i_dut (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn),
    .bus_req_i      (bus_req),
    .bus_rsp_o      (bus_rsp),
    .line_in_i      (line_in),
    .line_out_o     (line_out),
    .tick_48k_o     (tick_48k),
    .tick_8k_o      (tick_8k),
    .irq_play_o     (irq_play),
    .irq_rec_o      (irq_rec)
  );

  bind ac97_ctrl_top ac97_ctrl_asserts i_asserts (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .bus_req_i      (bus_req_i),
    .rsp_i          (bus_rsp_o),
    .line_out_i     (line_out_o),
    .tick_48k_i     (tick_48k_o),
    .tick_8k_i      (tick_8k_o)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: %s: expected %08h, got %08h",
                          $time, what, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one register access, returns after the acknowledge
  task automatic bus_access(input logic wr, input logic [19:0] offs,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    bus_req.addr  <= {12'h400, offs};            // base above the decoded bits
    bus_req.wdata <= wdata;
    bus_req.we    <= wr;
    bus_req.re    <= !wr;
    @(posedge clk_adc_125mhz);
    bus_req.we <= 1'b0;
    bus_req.re <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk_adc_125mhz);
      waited = waited + 1;
    end while (!bus_rsp.ack && waited < 4);
    if (!bus_rsp.ack) begin
      abort_run($sformatf("bus acknowledge never came for offset %05h", offs));
    end
    check(waited, 1, "acknowledge latency");
    rdata = bus_rsp.rdata;
  endtask

  task automatic model_write(input logic [19:0] offs, input logic [31:0] data);
    sample_pair_t pair;
    if (offs == `AC97_REG_PLAY) begin
      if (play_right_m) begin
        pair.left  = play_left_m;
        pair.right = data[15:0];
        if (play_q.size() < `AC97_FIFO_DEPTH) begin
          play_q.push_back(pair);                // full fifo drops the pair
        end
      end else begin
        play_left_m = data[15:0];
      end
      play_right_m = !play_right_m;
    end else if (offs == `AC97_REG_FIFO_RST) begin
      if (data[0]) begin
        play_q.delete();
        play_right_m = 1'b0;
        underrun_m   = 1'b0;
      end
      if (data[1]) begin
        rec_q.delete();
        rec_right_m = 1'b0;
        overrun_m   = 1'b0;
      end
    end
  endtask

  // left first, right read releases the pair
  function automatic logic [31:0] rec_model_read();
    logic [31:0] v;
    v = '0;
    if (rec_q.size() != 0) begin
      v = {16'h0, rec_right_m ? rec_q[0].right : rec_q[0].left};
      if (rec_right_m) begin
        void'(rec_q.pop_front());
      end
      rec_right_m = !rec_right_m;
    end
    return v;
  endfunction

  task automatic check_status();
    logic [31:0] rdata;
    logic [7:0]  exp;
    exp = {overrun_m, underrun_m, 2'b11,         // ready and access finished
           rec_q.size() == 0, rec_q.size() == `AC97_FIFO_DEPTH,
           play_q.size() <= `AC97_FIFO_DEPTH / 2, play_q.size() == `AC97_FIFO_DEPTH};
    bus_access(1'b0, `AC97_REG_STAT, '0, rdata);
    check(rdata, {24'h0, exp}, "status register");
    check(irq_play, play_q.size() <= `AC97_PLAY_IRQ_MAX, "irq_play level");
    check(irq_rec, rec_q.size() >= `AC97_REC_IRQ_MIN, "irq_rec level");
  endtask

  task automatic wait_ticks(input int n);
    int seen;
    int cyc;
    seen = 0;
    cyc  = 0;
    while (seen < n) begin
      @(posedge clk_adc_125mhz);
      cyc = cyc + 1;
      if (tick_48k) begin
        seen = seen + 1;
        cyc  = 0;
      end
      if (cyc > 3000) begin
        abort_run("no 48 kHz tick within 3000 cycles");
      end
    end
    @(posedge clk_adc_125mhz);                   // monitor has taken the tick
  endtask

  // ----------------------------------------
  // tick monitor and stream models
  // ----------------------------------------
  always @(posedge clk_adc_125mhz) begin : tick_monitor
    if (adc_rstn) begin
      gap_cnt = gap_cnt + 1;
      if (line_due) begin
        check(line_out, line_exp, "line_out pair");
        line_due = 1'b0;
      end
      if (tick_48k) begin
        long_exp = ((n_48k % `AC97_TICK_FRAC) == `AC97_TICK_FRAC - 1);  // every sixth
        check(tick_8k, long_exp, "8 kHz tick position");
        if (n_48k != 0) begin
          check(gap_cnt, long_exp ? `AC97_TICK_RUN + 1 : `AC97_TICK_RUN, "48 kHz period");
        end
        n_48k = n_48k + 1;
        if (tick_8k) begin
          if (n_8k != 0) begin
            check(since_8k + 1, `AC97_TICK_FRAC, "48 kHz ticks per 8 kHz tick");
          end
          n_8k     = n_8k + 1;
          since_8k = 0;
        end else begin
          since_8k = since_8k + 1;
        end
        if (play_q.size() != 0) begin
          line_exp = play_q.pop_front();         // shows up next cycle
          line_due = 1'b1;
        end else begin
          underrun_m = 1'b1;
        end
        if (rec_q.size() < `AC97_FIFO_DEPTH) begin
          rec_q.push_back(line_in);
        end else begin
          overrun_m = 1'b1;                      // pair lost
        end
        rng = xorshift32(rng);
        line_in <= rng;
        gap_cnt   = 0;
      end
    end
  end

  initial begin : watchdog
    int budget;
    budget = 500;                                // reset and final checks
    foreach (tbl[i]) begin
      budget = budget + ((tbl[i].op == OP_TICKS) ? int'(tbl[i].data) * 3000 : 3000);
    end
    repeat (budget) @(posedge clk_adc_125mhz);
    abort_run($sformatf("watchdog expired after %0d cycles", budget));
  end

  // ----------------------------------------
  // table sequencer
  // ----------------------------------------
  initial begin : run_table
    logic [31:0] rdata;
    logic [31:0] expv;
    logic [31:0] wval;
    int          k;
    bus_req = '0;
    rng     = xorshift32(32'd56712);
    line_in = rng;
    wait (adc_rstn === 1'b1);
    @(posedge clk_adc_125mhz);
    foreach (tbl[i]) begin
      case (tbl[i].op)
        OP_IDLE: repeat (tbl[i].data) @(posedge clk_adc_125mhz);
        OP_WR: begin
          bus_access(1'b1, tbl[i].offs, tbl[i].data, rdata);
          model_write(tbl[i].offs, tbl[i].data);
        end
        OP_RD: begin
          bus_access(1'b0, tbl[i].offs, '0, rdata);
          check(rdata, tbl[i].exp, $sformatf("read of offset %05h", tbl[i].offs));
        end
        OP_REC: begin
          repeat (tbl[i].data) begin
            expv = rec_model_read();
            bus_access(1'b0, `AC97_REG_REC, '0, rdata);
            check(rdata, expv, "record sample read");
          end
        end
        OP_FILL: begin
          for (k = 0; k < 2 * int'(tbl[i].data); k++) begin
            wval = 32'h0000_C000 + k;            // distinct word per write
            bus_access(1'b1, `AC97_REG_PLAY, wval, rdata);
            model_write(`AC97_REG_PLAY, wval);
          end
        end
        OP_STAT:  check_status();
        OP_TICKS: wait_ticks(int'(tbl[i].data));
        default:  abort_run($sformatf("unknown table operation in row %0d", i));
      endcase
    end
    check(n_8k >= 2, 1'b1, "8 kHz ticks seen");
    if (i_dut.i_asserts.fail_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run($sformatf("%0d bound assertion failures", i_dut.i_asserts.fail_cnt));
    end
  end

endmodule

// ==== sources.f ====
+incdir+.
ac97_bus_pkg.sv
ac97_audio_pkg.sv
ac97_sample_tick.sv
ac97_reg_decode.sv
ac97_sample_fifo.sv
ac97_codec_regs.sv
ac97_stream_status.sv
ac97_ctrl_top.sv
ac97_ctrl_asserts.sv
tb_clock_gen.sv
tb_ac97_ctrl.sv
